//--- src/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// machine word as seen by the ALU, registers and the data cache
`define DATA_W 32

// byte address, the cache splits it into tag, index and byte offset
`define ADDR_W 32

// direct-mapped cache size in lines of one word, keep it a power of two
`define CACHE_LINES 16

`endif

//--- src/pipe_pkg.sv
`default_nettype none

`include "mips_params.svh"

package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        logic [`DATA_W-1:0] inst_addr;
        logic [`DATA_W-1:0] rs_data;
        logic [`DATA_W-1:0] rt_data;
        logic [`DATA_W-1:0] imm_extend;
        logic [4:0]         rd_num;
        alu_op_t            alu_op;
        logic               use_imm;       // operand b comes from imm_extend
        logic               branch;
        logic               jump;
        logic               jump_register;
        logic               mem_read;
        logic               mem_write;
        logic               is_word;       // low means a single byte access
        logic               register_write;
        logic               is_nop;
        logic               halted;
    } ex_in_t;

    typedef struct packed {
        logic [`DATA_W-1:0] alu_result;    // also the memory address for loads and stores
        logic [`DATA_W-1:0] rt_data;
        logic [`DATA_W-1:0] inst_addr;
        logic [4:0]         rd_num;
        logic               register_write;
        logic               mem_read;
        logic               mem_write;
        logic               is_word;
        logic               is_nop;
        logic               halted;
    } ex_mem_t;

    typedef struct packed {
        logic               valid;
        logic [4:0]         rd_num;
        logic               register_write;
        logic [`DATA_W-1:0] data;
        logic               halted;
    } wb_t;

    typedef struct packed {
        logic               taken;
        logic [`DATA_W-1:0] target;
    } redirect_t;

    // bubble that fills EX/MEM after reset or when nothing is accepted
    localparam ex_mem_t EX_MEM_NOP = '{
        alu_result:     '0,
        rt_data:        '0,
        inst_addr:      '0,
        rd_num:         '0,
        register_write: 1'b0,
        mem_read:       1'b0,
        mem_write:      1'b0,
        is_word:        1'b0,
        is_nop:         1'b1,
        halted:         1'b0
    };

endpackage

`default_nettype wire

//--- src/mem_pkg.sv
`default_nettype none

`include "mips_params.svh"

package mem_pkg;

    localparam int IDX_W = $clog2(`CACHE_LINES);
    localparam int TAG_W = `ADDR_W - IDX_W - 2;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] index;
        logic [1:0]       offset;   // byte within the word
    } cache_fields_t;

    // the same address word, taken whole or split for the cache lookup
    typedef union packed {
        logic [`ADDR_W-1:0] raw;
        cache_fields_t      f;
    } cache_addr_u;

    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [`ADDR_W-1:0] adr;
        logic [`DATA_W-1:0] dat_w;
        logic [3:0]         sel;
    } wb_req_t;

    typedef struct packed {
        logic               ack;
        logic [`DATA_W-1:0] dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- src/execute_stage.sv
`default_nettype none

`include "mips_params.svh"

module execute_stage import pipe_pkg::*; (
    input  ex_in_t    ex_in,
    input  logic      in_valid,
    output ex_mem_t   ex_mem,
    output redirect_t redirect
);

    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] alu_result;
    logic [`DATA_W-1:0] diff;
    logic [`DATA_W-1:0] pc_plus4;
    logic               zero;
    logic               live;

    assign live     = in_valid && !ex_in.is_nop;
    assign op_b     = ex_in.use_imm ? ex_in.imm_extend : ex_in.rt_data;
    assign diff     = ex_in.rs_data - ex_in.rt_data;
    assign zero     = (diff == '0);   // branch compare always uses rs and rt
    assign pc_plus4 = ex_in.inst_addr + `DATA_W'(4);

    always_comb begin
        case (ex_in.alu_op)
            ALU_ADD:    alu_result = ex_in.rs_data + op_b;
            ALU_SUB:    alu_result = ex_in.rs_data - op_b;
            ALU_AND:    alu_result = ex_in.rs_data & op_b;
            ALU_OR:     alu_result = ex_in.rs_data | op_b;
            ALU_SLT:    alu_result = {{(`DATA_W-1){1'b0}},
                                      $signed(ex_in.rs_data) < $signed(op_b)};
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    always_comb begin
        redirect.taken  = 1'b0;
        redirect.target = pc_plus4;
        if (live) begin
            if (ex_in.jump_register) begin
                redirect.taken  = 1'b1;
                redirect.target = ex_in.rs_data;
            end else if (ex_in.jump) begin
                redirect.taken  = 1'b1;
                redirect.target = pc_plus4 + ex_in.imm_extend;
            end else if (ex_in.branch && zero) begin
                redirect.taken  = 1'b1;
                redirect.target = pc_plus4 + (ex_in.imm_extend << 2);   // word offset
            end
        end
        if (in_valid) begin
            assert (!(ex_in.branch && ex_in.jump))
                else $error("execute: branch and jump set on the same item");
        end
    end

    always_comb begin
        if (!in_valid) begin
            ex_mem = EX_MEM_NOP;   // nothing accepted this cycle
        end else begin
            ex_mem.alu_result     = alu_result;
            ex_mem.rt_data        = ex_in.rt_data;
            ex_mem.inst_addr      = ex_in.inst_addr;
            ex_mem.rd_num         = ex_in.rd_num;
            ex_mem.register_write = ex_in.register_write;
            ex_mem.mem_read       = ex_in.mem_read;
            ex_mem.mem_write      = ex_in.mem_write;
            ex_mem.is_word        = ex_in.is_word;
            ex_mem.is_nop         = ex_in.is_nop;
            ex_mem.halted         = ex_in.halted;
        end
    end

endmodule

`default_nettype wire

//--- src/buffer_ex_mem.sv
`default_nettype none

module buffer_ex_mem import pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    hold,
    input  ex_mem_t d,
    output ex_mem_t q
);

    // whole EX/MEM record in one register that holds while the memory stage stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= EX_MEM_NOP;
        end else if (!hold) begin
            q <= d;
        end
    end

    // only a real load or store can keep its record stuck in MEM
    assert property (@(posedge clk) disable iff (!rst_n)
                     hold |-> (!q.is_nop && (q.mem_read || q.mem_write)))
        else $error("ex/mem buffer held for an item that does not access memory");

endmodule

`default_nettype wire

//--- src/data_cache.sv
`default_nettype none

`include "mips_params.svh"

module data_cache import mem_pkg::*; #(
    parameter int LINES = `CACHE_LINES
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  cache_addr_u        addr,
    input  logic               we,
    input  logic [`DATA_W-1:0] wdata,
    input  logic [3:0]         sel,
    output logic [`DATA_W-1:0] rdata,
    output logic               stall,
    output wb_req_t            bus_req,
    input  wb_rsp_t            bus_rsp
);

    localparam int LIDX_W = $clog2(LINES);
    localparam int LTAG_W = `ADDR_W - LIDX_W - 2;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE_BACK,
        S_REFILL
    } state_t;

    state_t state;
    state_t state_next;

    logic [LTAG_W-1:0]  tag_mem  [LINES];
    logic [`DATA_W-1:0] data_mem [LINES];
    logic [LINES-1:0]   valid_bits;
    logic [LINES-1:0]   dirty_bits;

    logic [LIDX_W-1:0]  idx;
    logic [LTAG_W-1:0]  tag;
    logic               hit;
    logic               victim_dirty;
    logic               full_store;
    logic               write_now;
    logic [`DATA_W-1:0] merged;

    assign idx          = addr.raw[LIDX_W+1:2];
    assign tag          = addr.raw[`ADDR_W-1:LIDX_W+2];
    assign hit          = valid_bits[idx] && (tag_mem[idx] == tag);
    assign victim_dirty = valid_bits[idx] && dirty_bits[idx];
    assign full_store   = we && (sel == 4'b1111);   // needs no refill and just takes the line
    assign rdata        = data_mem[idx];

    assign stall = (state != S_IDLE) ||
                   (req_valid && !hit && (victim_dirty || !full_store));
    assign write_now = req_valid && we && !stall;

    always_comb begin
        merged = data_mem[idx];
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    // every bus access returns to idle so cyc drops between the eviction and the refill
    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (req_valid && !hit) begin
                    if (victim_dirty) begin
                        state_next = S_WRITE_BACK;
                    end else if (!full_store) begin
                        state_next = S_REFILL;
                    end
                end
            end
            S_WRITE_BACK, S_REFILL: begin
                if (bus_rsp.ack) begin
                    state_next = S_IDLE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_comb begin
        bus_req.cyc   = (state != S_IDLE);
        bus_req.stb   = (state != S_IDLE);
        bus_req.we    = (state == S_WRITE_BACK);
        bus_req.adr   = (state == S_WRITE_BACK) ? {tag_mem[idx], idx, 2'b00}
                                                : {tag, idx, 2'b00};
        bus_req.dat_w = data_mem[idx];
        bus_req.sel   = 4'b1111;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            state <= state_next;
            if (state == S_REFILL && bus_rsp.ack) begin
                valid_bits[idx] <= 1'b1;
                dirty_bits[idx] <= 1'b0;
            end else if (state == S_WRITE_BACK && bus_rsp.ack) begin
                dirty_bits[idx] <= 1'b0;   // memory now holds the victim
            end else if (write_now) begin
                valid_bits[idx] <= 1'b1;
                dirty_bits[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_REFILL && bus_rsp.ack) begin
            data_mem[idx] <= bus_rsp.dat_r;
            tag_mem[idx]  <= tag;
        end else if (write_now) begin
            data_mem[idx] <= merged;
            tag_mem[idx]  <= tag;
        end
    end

    // the master releases the bus in the cycle after each ack
    assert property (@(posedge clk) disable iff (!rst_n)
                     (bus_req.cyc && bus_rsp.ack) |=> !(bus_req.cyc || bus_req.stb))
        else $error("wishbone cycle still open after ack");

    assert property (@(posedge clk) disable iff (!rst_n)
                     (bus_req.stb && !bus_rsp.ack) |=> $stable(bus_req.adr))
        else $error("wishbone adr moved before ack");

endmodule

`default_nettype wire

//--- src/memory_stage.sv
`default_nettype none

`include "mips_params.svh"

module memory_stage import pipe_pkg::*, mem_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem,
    output logic    stall,
    output wb_t     wb_out,
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp
);

    cache_addr_u        addr;
    logic               req_valid;
    logic [3:0]         sel;
    logic [`DATA_W-1:0] wdata;
    logic [`DATA_W-1:0] rdata;
    logic [7:0]         load_byte;
    logic [`DATA_W-1:0] load_data;
    logic [`DATA_W-1:0] wb_data;

    assign addr      = cache_addr_u'(ex_mem.alu_result);
    assign req_valid = !ex_mem.is_nop && (ex_mem.mem_read || ex_mem.mem_write);

    // byte stores put the byte on every lane and let sel pick the right one
    assign sel   = ex_mem.is_word ? 4'b1111 : (4'b0001 << addr.f.offset);
    assign wdata = ex_mem.is_word ? ex_mem.rt_data : {4{ex_mem.rt_data[7:0]}};

    assign load_byte = rdata[{addr.f.offset, 3'b000} +: 8];
    assign load_data = ex_mem.is_word ? rdata : {{(`DATA_W-8){load_byte[7]}}, load_byte};
    assign wb_data   = ex_mem.mem_read ? load_data : ex_mem.alu_result;

    data_cache #(
        .LINES(`CACHE_LINES)
    ) i_data_cache (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_valid(req_valid),
        .addr     (addr),
        .we       (ex_mem.mem_write),
        .wdata    (wdata),
        .sel      (sel),
        .rdata    (rdata),
        .stall    (stall),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_out <= '0;
        end else if (!stall) begin
            wb_out.valid          <= !ex_mem.is_nop;
            wb_out.rd_num         <= ex_mem.rd_num;
            wb_out.register_write <= ex_mem.register_write;
            wb_out.data           <= wb_data;
            wb_out.halted         <= ex_mem.halted;
        end else begin
            wb_out.valid <= 1'b0;   // nothing retires while the cache is busy
        end
    end

endmodule

`default_nettype wire

//--- src/pipe_ex_mem_top.sv
`default_nettype none

module pipe_ex_mem_top import pipe_pkg::*, mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  ex_in_t    ex_in,
    input  logic      in_valid,
    output logic      ready,
    output redirect_t redirect,
    output wb_t       wb_out,
    output wb_req_t   bus_req,
    input  wb_rsp_t   bus_rsp
);

    logic    accept;
    logic    stall;
    logic    halt_seen;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;

    assign ready  = !stall && !halt_seen;
    assign accept = in_valid && ready;   // redirect and the new record only for accepted items

    execute_stage i_execute_stage (
        .ex_in   (ex_in),
        .in_valid(accept),
        .ex_mem  (ex_mem_d),
        .redirect(redirect)
    );

    buffer_ex_mem i_buffer_ex_mem (
        .clk  (clk),
        .rst_n(rst_n),
        .hold (stall),
        .d    (ex_mem_d),
        .q    (ex_mem_q)
    );

    memory_stage i_memory_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem_q),
        .stall  (stall),
        .wb_out (wb_out),
        .bus_req(bus_req),
        .bus_rsp(bus_rsp)
    );

    // once a halted item retires the slice takes nothing more
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt_seen <= 1'b0;
        end else if (wb_out.valid && wb_out.halted) begin
            halt_seen <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_pipe_ex_mem.sv
`default_nettype none

`include "mips_params.svh"

module tb_pipe_ex_mem import pipe_pkg::*, mem_pkg::*; ();

    typedef logic [`DATA_W-1:0] word_t;
    localparam int N = 27;

    logic clk = 1'b0;
    logic rst_n;
    logic in_valid;
    logic ready;
    ex_in_t ex_in;
    redirect_t redirect;
    wb_t wb_out;
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;

    string names [N];
    ex_in_t stim [N];
    logic stim_valid [N];
    logic exp_taken [N];
    word_t exp_target [N];
    word_t exp_data [N];
    int exp_reads [N];
    int exp_writes [N];
    int n_rows = 0;

    word_t mem [256];      // memory behind the Wishbone slave
    word_t ref_mem [256];  // what memory must hold once every accepted store lands
    wb_t exp_q [$];
    int idx_q [$];
    int cyc_q [$];
    int cycle_count = 0;
    int reads = 0;
    int writes = 0;
    int seed = 32'hdcf;

    pipe_ex_mem_top i_pipe_ex_mem_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .ex_in   (ex_in),
        .in_valid(in_valid),
        .ready   (ready),
        .redirect(redirect),
        .wb_out  (wb_out),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic flag_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
        $display("test failed");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic word_t fill_word(input logic [7:0] w);
        return {8'h5a, w, ~w, w ^ 8'h80};   // bit 7 of byte 0 set for the low words
    endfunction

    function automatic ex_in_t alu_item(input alu_op_t op, input word_t a, input word_t b,
                                        input logic imm, input logic [4:0] rd);
        ex_in_t r;
        r = '0;
        r.rs_data = a;
        r.rt_data = imm ? '0 : b;
        r.imm_extend = imm ? b : '0;
        r.alu_op = op;
        r.use_imm = imm;
        r.rd_num = rd;
        r.register_write = 1'b1;
        return r;
    endfunction

    // kind is {branch, jump, jump_register} and the alu adds rs and rt
    function automatic ex_in_t ctl_item(input word_t pc, input word_t a, input word_t b,
                                        input word_t imm, input logic [2:0] kind);
        ex_in_t r;
        r = alu_item(ALU_ADD, a, b, 1'b0, 5'd0);
        r.inst_addr = pc;
        r.imm_extend = imm;
        r.register_write = 1'b0;
        {r.branch, r.jump, r.jump_register} = kind;
        return r;
    endfunction

    function automatic ex_in_t mem_item(input logic load, input logic is_word, input word_t base,
                                        input word_t off, input word_t data, input logic [4:0] rd);
        ex_in_t r;
        r = alu_item(ALU_ADD, base, off, 1'b1, rd);
        r.rt_data = data;
        r.mem_read = load;
        r.mem_write = !load;
        r.is_word = is_word;
        r.register_write = load;
        return r;
    endfunction

    task automatic add_row(input string name, input ex_in_t item, input logic vld,
                           input logic taken, input word_t target, input word_t data,
                           input int rd_cnt, input int wr_cnt);
        names[n_rows] = name;
        stim[n_rows] = item;
        stim_valid[n_rows] = vld;
        exp_taken[n_rows] = taken;
        exp_target[n_rows] = target;
        exp_data[n_rows] = data;
        exp_reads[n_rows] = rd_cnt;
        exp_writes[n_rows] = wr_cnt;
        n_rows++;
    endtask

    task automatic build_table();
        ex_in_t r;
        add_row("add", alu_item(ALU_ADD, 32'd7, 32'd5, 1'b0, 5'd1), 1, 0, '0, 32'd12, 0, 0);
        add_row("sub", alu_item(ALU_SUB, 32'd7, 32'd9, 1'b0, 5'd2), 1, 0, '0, 32'hffff_fffe, 0, 0);
        add_row("and", alu_item(ALU_AND, 32'hf0f0, 32'h0ff0, 1'b0, 5'd3), 1, 0, '0, 32'h00f0, 0, 0);
        add_row("or", alu_item(ALU_OR, 32'hf000, 32'h000f, 1'b0, 5'd4), 1, 0, '0, 32'hf00f, 0, 0);
        add_row("slt_neg", alu_item(ALU_SLT, 32'hffff_fffd, 32'd2, 1'b0, 5'd5), 1, 0, '0, 1, 0, 0);
        add_row("slt_pos", alu_item(ALU_SLT, 32'd5, 32'd2, 1'b0, 5'd6), 1, 0, '0, 0, 0, 0);
        add_row("addi", alu_item(ALU_ADD, 32'd100, 32'hffff_fff6, 1'b1, 5'd7), 1, 0, '0, 90, 0, 0);
        add_row("pass_b", alu_item(ALU_PASS_B, 32'd1, 32'h55, 1'b1, 5'd8), 1, 0, '0, 32'h55, 0, 0);
        add_row("beq_taken", ctl_item(32'h100, 3, 3, 4, 3'b100), 1, 1, 32'h114, 6, 0, 0);
        add_row("beq_not", ctl_item(32'h104, 3, 4, 4, 3'b100), 1, 0, '0, 7, 0, 0);
        add_row("jump", ctl_item(32'h200, 0, 0, 32'h40, 3'b010), 1, 1, 32'h244, 0, 0, 0);
        add_row("jr", ctl_item(32'h300, 32'h1234, 0, 0, 3'b001), 1, 1, 32'h1234, 32'h1234, 0, 0);
        add_row("sw_a", mem_item(0, 1, 32'h40, 0, 32'hcafe_f00d, 0), 1, 0, '0, 32'h40, 0, 0);
        add_row("lw_a", mem_item(1, 1, 32'h40, 0, 0, 5'd9), 1, 0, '0, 32'hcafe_f00d, 0, 0);
        add_row("sb_a", mem_item(0, 0, 32'h40, 2, 32'hf3, 0), 1, 0, '0, 32'h42, 0, 0);
        add_row("lb_a", mem_item(1, 0, 32'h40, 2, 0, 5'd10), 1, 0, '0, 32'hffff_fff3, 0, 0);
        add_row("lw_a2", mem_item(1, 1, 32'h40, 0, 0, 5'd11), 1, 0, '0, 32'hcaf3_f00d, 0, 0);
        add_row("lw_evict", mem_item(1, 1, 32'h80, 0, 0, 5'd12), 1, 0, '0, fill_word(8'h20), 1, 1);
        // word 0x31 comes from the fill and its byte 1 is 0xce
        add_row("lb_miss", mem_item(1, 0, 32'hc0, 5, 0, 5'd13), 1, 0, '0, 32'hffff_ffce, 2, 1);
        add_row("lw_back", mem_item(1, 1, 32'h40, 0, 0, 5'd14), 1, 0, '0, 32'hcaf3_f00d, 3, 1);
        add_row("sb_miss", mem_item(0, 0, 32'h80, 3, 32'h7e, 0), 1, 0, '0, 32'h83, 4, 1);
        add_row("lw_after", mem_item(1, 1, 32'h80, 0, 0, 5'd15), 1, 0, '0, 32'h7e20_dfa0, 4, 1);
        add_row("sw_evict", mem_item(0, 1, 32'h0, 0, 32'h1122_3344, 0), 1, 0, '0, 0, 4, 2);
        add_row("lw_zero", mem_item(1, 1, 32'h0, 0, 0, 5'd16), 1, 0, '0, 32'h1122_3344, 4, 2);
        r = alu_item(ALU_ADD, 32'd3, 32'd4, 1'b0, 5'd17);
        add_row("idle", r, 0, 0, '0, 0, 4, 2);
        r.is_nop = 1'b1;
        add_row("nop", r, 1, 0, '0, 0, 4, 2);
        r = alu_item(ALU_ADD, 32'd1, 32'd1, 1'b0, 5'd18);
        r.halted = 1'b1;
        add_row("halt", r, 1, 0, '0, 2, 4, 2);
    endtask

    // drives one row and returns one cycle after the DUT has taken it
    task automatic present(input int k);
        wb_t e;
        word_t a;
        ex_in = stim[k];
        in_valid = stim_valid[k];
        while (stim_valid[k] && !ready) begin
            @(posedge clk);
            #1;
        end
        #1;   // redirect follows the item just driven
        assert (redirect.taken == exp_taken[k])
            else flag_mismatch({names[k], " taken"}, 64'(exp_taken[k]), 64'(redirect.taken));
        if (exp_taken[k]) begin
            assert (redirect.target == exp_target[k])
                else flag_mismatch({names[k], " target"}, 64'(exp_target[k]),
                                   64'(redirect.target));
        end
        if (stim_valid[k] && !stim[k].is_nop) begin
            e = '{valid: 1'b1, rd_num: stim[k].rd_num, register_write: stim[k].register_write,
                  data: exp_data[k], halted: stim[k].halted};
            exp_q.push_back(e);
            idx_q.push_back(k);
            cyc_q.push_back(cycle_count);
            if (stim[k].mem_write) begin
                a = stim[k].rs_data + stim[k].imm_extend;
                if (stim[k].is_word) begin
                    ref_mem[a[9:2]] = stim[k].rt_data;
                end else begin
                    ref_mem[a[9:2]][{a[1:0], 3'b000} +: 8] = stim[k].rt_data[7:0];
                end
            end
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        ex_in = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(8'(i));
            ref_mem[i] = mem[i];
        end
        build_table();
        assert (n_rows == N) else report_failure("stimulus table size does not match N");
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int k = 0; k < N; k++) begin
            present(k);
        end
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);   // the halt latch closes on this edge
        #1;
        ex_in = stim[0];
        in_valid = 1'b1;
        repeat (10) begin
            assert (!ready) else report_failure("ready rose again after the halted item retired");
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        $display("test passed");
        $finish;
    end

    // Wishbone slave with a random 0 to 3 cycle wait before each ack
    initial begin
        logic [7:0] w;
        int wait_left;
        wait_left = -1;
        bus_rsp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (bus_rsp.ack) begin
                bus_rsp.ack = 1'b0;   // single-cycle ack
            end else if (rst_n && bus_req.cyc && bus_req.stb) begin
                if (wait_left < 0) begin
                    wait_left = $unsigned($random(seed)) % 4;
                end
                if (wait_left == 0) begin
                    w = bus_req.adr[9:2];
                    assert (bus_req.sel == 4'b1111)
                        else report_failure("bus access without a full byte select");
                    if (bus_req.we) begin
                        writes++;
                        assert (bus_req.dat_w == ref_mem[w])
                            else flag_mismatch("eviction data", 64'(ref_mem[w]),
                                               64'(bus_req.dat_w));
                        mem[w] = bus_req.dat_w;
                    end else begin
                        reads++;
                        bus_rsp.dat_r = mem[w];
                    end
                    bus_rsp.ack = 1'b1;
                    wait_left = -1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // results must retire in table order
    initial begin
        wb_t e;
        int k;
        int t;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && wb_out.valid) begin
                assert (exp_q.size() != 0)
                    else report_failure("write-back appeared with no item pending");
                e = exp_q.pop_front();
                k = idx_q.pop_front();
                t = cyc_q.pop_front();
                assert (wb_out == e) else flag_mismatch(names[k], 64'(e), 64'(wb_out));
                if (!stim[k].mem_read && !stim[k].mem_write) begin
                    assert (cycle_count - t == 2)
                        else flag_mismatch({names[k], " latency"}, 2, 64'(cycle_count - t));
                end
                assert (reads == exp_reads[k])
                    else flag_mismatch({names[k], " bus reads"}, 64'(exp_reads[k]), 64'(reads));
                assert (writes == exp_writes[k])
                    else flag_mismatch({names[k], " bus writes"}, 64'(exp_writes[k]),
                                       64'(writes));
            end
        end
    end

    initial begin
        #(N * 40 * 4 + 5 * 4);
        $display("timeout: the pipeline did not finish the stimulus table in time");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/pipe_pkg.sv
src/mem_pkg.sv
src/execute_stage.sv
src/buffer_ex_mem.sv
src/data_cache.sv
src/memory_stage.sv
src/pipe_ex_mem_top.sv
bench/tb_pipe_ex_mem.sv

//--- run.sh
#!/bin/sh
# compile the EX/MEM slice with its testbench under Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_pipe_ex_mem -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
